//--- internal_bus.f
logic/internal_bus_pkg.sv
logic/start_manager.sv
logic/mem_manager.sv
logic/state_manager.sv
logic/alu.sv
logic/finish_manager.sv
logic/internal_bus.sv
testbench/clock_gen.sv
testbench/tb_internal_bus.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import internal_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  state_t            state,
  input  cmd_word_u         command,
  input  logic [data_w-1:0] src1,
  input  logic [data_w-1:0] src0,
  output logic [data_w-1:0] result,
  output logic [data_w-1:0] result_h,
  output logic              flag_zero,
  output logic              flag_neg,
  output logic              flag_carry,
  output logic              flags_valid
);

  logic [data_w:0]     wide;
  logic [2*data_w-1:0] product;
  logic [data_w-1:0]   res_n;
  logic [data_w-1:0]   res_h_n;
  logic                carry_n;
  logic [4:0]          shamt;
  logic                do_exec;

  assign shamt   = src0[4:0];
  assign product = {{data_w{1'b0}}, src1} * {{data_w{1'b0}}, src0};

  // jmp and hlt pass through exec without touching result or flags
  assign do_exec = (state == st_exec) && (command.arith.op != op_jmp)
                   && (command.arith.op != op_hlt);

  always_comb begin
    wide    = '0;
    res_n   = '0;
    res_h_n = '0;
    carry_n = 1'b0;
    case (command.arith.op)
      op_add: begin
        wide    = {1'b0, src1} + {1'b0, src0};
        res_n   = wide[data_w-1:0];
        carry_n = wide[data_w];
      end
      op_sub: begin
        // top bit is the borrow
        wide    = {1'b0, src1} - {1'b0, src0};
        res_n   = wide[data_w-1:0];
        carry_n = wide[data_w];
      end
      op_and: res_n = src1 & src0;
      op_or:  res_n = src1 | src0;
      op_xor: res_n = src1 ^ src0;
      op_shl: begin
        wide    = {1'b0, src1} << shamt;
        res_n   = wide[data_w-1:0];
        carry_n = wide[data_w];
      end
      op_shr: begin
        // extra low bit catches the last bit shifted out
        wide    = {src1, 1'b0} >> shamt;
        res_n   = wide[data_w:1];
        carry_n = wide[0];
      end
      op_mov: res_n = src1;
      op_mul: begin
        res_n   = product[data_w-1:0];
        res_h_n = product[2*data_w-1:data_w];
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flag_zero   <= 1'b0;
      flag_neg    <= 1'b0;
      flag_carry  <= 1'b0;
      flags_valid <= 1'b0;
    end else begin
      flags_valid <= do_exec;
      if (do_exec) begin
        flag_zero  <= (res_n == '0);
        flag_neg   <= res_n[data_w-1];
        flag_carry <= carry_n;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_exec) begin
      result   <= res_n;
      result_h <= res_h_n;
    end
  end

endmodule

//--- logic/finish_manager.sv
`timescale 1ns/1ps

module finish_manager import internal_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  state_t            state,
  input  cmd_word_u         command,
  output logic [addr_w-1:0] cmd_ptr,
  output logic              finish_step_done
);

  // set when the command went through exec, so its condition held
  logic ran_exec;

  // pointer update always fits in the single finish cycle
  assign finish_step_done = (state == st_finish);

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_ptr  <= '0;
      ran_exec <= 1'b0;
    end else begin
      if (state == st_fetch) begin
        ran_exec <= 1'b0;
      end else if (state == st_exec) begin
        ran_exec <= 1'b1;
      end
      if (state == st_finish) begin
        if (ran_exec && command.jump.op == op_jmp) begin
          cmd_ptr <= command.jump.target;
        end else begin
          // also steps over a skipped command
          cmd_ptr <= cmd_ptr + 16'd1;
        end
      end
    end
  end

endmodule

//--- logic/internal_bus.sv
`timescale 1ns/1ps

module internal_bus import internal_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              disp_online,
  input  logic              halt_q,
  input  logic              read_dn,
  input  logic              write_dn,
  input  logic [data_w-1:0] mem_rdata,
  output logic              read_q,
  output logic              write_q,
  output logic [addr_w-1:0] mem_addr,
  output logic [data_w-1:0] mem_wdata,
  output logic              halted,
  output state_t            state
);

  logic              fetch_q;
  logic [addr_w-1:0] fetch_addr;
  cmd_word_u         command;
  logic              start_step_done;

  logic              mem_read_q;
  logic              mem_write_q;
  logic [addr_w-1:0] mem_addr_o;
  logic [data_w-1:0] mem_wdata_o;
  logic [data_w-1:0] src1;
  logic [data_w-1:0] src0;
  logic              mem_step_done;

  logic [data_w-1:0] result;
  logic [data_w-1:0] result_h;
  logic              flag_zero;
  logic              flag_neg;
  logic              flag_carry;
  logic              flags_valid;

  logic [addr_w-1:0] cmd_ptr;
  logic              finish_step_done;

  logic              in_fetch;
  logic              in_load;
  logic              in_store;

  assign in_fetch = (state == st_fetch);
  assign in_load  = (state == st_load_src1) || (state == st_load_src0);
  assign in_store = (state == st_store_dst) || (state == st_store_dst_h);

  // memory port belongs to the manager that owns the state
  assign read_q    = in_fetch ? fetch_q : (in_load && mem_read_q);
  assign write_q   = in_store && mem_write_q;
  assign mem_addr  = in_fetch ? fetch_addr : mem_addr_o;
  assign mem_wdata = mem_wdata_o;

  start_manager start_mng (
    .clk             (clk),
    .rst             (rst),
    .state           (state),
    .cmd_ptr         (cmd_ptr),
    .read_dn         (read_dn && in_fetch),
    .mem_rdata       (mem_rdata),
    .fetch_q         (fetch_q),
    .fetch_addr      (fetch_addr),
    .command         (command),
    .start_step_done (start_step_done)
  );

  mem_manager mem_mng (
    .clk           (clk),
    .rst           (rst),
    .state         (state),
    .command       (command),
    .read_dn       (read_dn && in_load),
    .write_dn      (write_dn && in_store),
    .mem_rdata     (mem_rdata),
    .result        (result),
    .result_h      (result_h),
    .mem_read_q    (mem_read_q),
    .mem_write_q   (mem_write_q),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .src1          (src1),
    .src0          (src0),
    .mem_step_done (mem_step_done)
  );

  state_manager states_mng (
    .clk              (clk),
    .rst              (rst),
    .disp_online      (disp_online),
    .halt_q           (halt_q),
    .command          (command),
    .start_step_done  (start_step_done),
    .mem_step_done    (mem_step_done),
    .finish_step_done (finish_step_done),
    .flag_zero        (flag_zero),
    .flag_neg         (flag_neg),
    .flag_carry       (flag_carry),
    .flags_valid      (flags_valid),
    .state            (state),
    .halted           (halted)
  );

  alu alu_1 (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .command     (command),
    .src1        (src1),
    .src0        (src0),
    .result      (result),
    .result_h    (result_h),
    .flag_zero   (flag_zero),
    .flag_neg    (flag_neg),
    .flag_carry  (flag_carry),
    .flags_valid (flags_valid)
  );

  finish_manager finish_mng (
    .clk              (clk),
    .rst              (rst),
    .state            (state),
    .command          (command),
    .cmd_ptr          (cmd_ptr),
    .finish_step_done (finish_step_done)
  );

endmodule

//--- logic/internal_bus_pkg.sv
package internal_bus_pkg;

  // bus and word sizes
  localparam int addr_w = 16;
  localparam int data_w = 32;

  // operand window, offsets in a command are relative to this
  localparam logic [addr_w-1:0] window_base = 16'h0100;

  typedef enum logic [3:0] {
    st_idle        = 4'd0,
    st_fetch       = 4'd1,
    st_load_src1   = 4'd2,
    st_load_src0   = 4'd3,
    st_exec        = 4'd4,
    st_store_dst   = 4'd5,
    st_store_dst_h = 4'd6,
    st_finish      = 4'd7,
    st_halted      = 4'd8
  } state_t;

  typedef enum logic [3:0] {
    op_add = 4'h0,
    op_sub = 4'h1,
    op_and = 4'h2,
    op_or  = 4'h3,
    op_xor = 4'h4,
    op_shl = 4'h5,
    op_shr = 4'h6,
    op_mov = 4'h7,
    op_mul = 4'h8,
    op_jmp = 4'h9,
    op_hlt = 4'ha
  } op_t;

  typedef enum logic [3:0] {
    cond_always   = 4'h0,
    cond_zero     = 4'h1,
    cond_nonzero  = 4'h2,
    cond_negative = 4'h3,
    cond_carry    = 4'h4
  } cond_t;

  // one command word, read either as an arithmetic or as a jump command
  typedef union packed {
    struct packed {
      op_t        op;
      cond_t      cond;
      logic [7:0] dst;
      logic [7:0] src1;
      logic [7:0] src0;
    } arith;
    struct packed {
      op_t               op;
      cond_t             cond;
      logic [7:0]        pad;
      logic [addr_w-1:0] target;
    } jump;
  } cmd_word_u;

endpackage

//--- logic/mem_manager.sv
`timescale 1ns/1ps

module mem_manager import internal_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  state_t            state,
  input  cmd_word_u         command,
  input  logic              read_dn,
  input  logic              write_dn,
  input  logic [data_w-1:0] mem_rdata,
  input  logic [data_w-1:0] result,
  input  logic [data_w-1:0] result_h,
  output logic              mem_read_q,
  output logic              mem_write_q,
  output logic [addr_w-1:0] mem_addr_o,
  output logic [data_w-1:0] mem_wdata_o,
  output logic [data_w-1:0] src1,
  output logic [data_w-1:0] src0,
  output logic              mem_step_done
);

  logic              is_load;
  logic              is_store;
  logic              raise;
  logic              read_hit;
  logic              write_hit;
  logic [addr_w-1:0] dst_addr;
  logic [addr_w-1:0] addr_n;

  assign is_load  = (state == st_load_src1) || (state == st_load_src0);
  assign is_store = (state == st_store_dst) || (state == st_store_dst_h);

  // new access once per state, never while one is open
  assign raise = (is_load || is_store) && !mem_read_q && !mem_write_q && !mem_step_done;

  assign read_hit  = mem_read_q && read_dn;
  assign write_hit = mem_write_q && write_dn;

  assign dst_addr = window_base + addr_w'(command.arith.dst);

  // window address for the current access
  always_comb begin
    case (state)
      st_load_src1:   addr_n = window_base + addr_w'(command.arith.src1);
      st_load_src0:   addr_n = window_base + addr_w'(command.arith.src0);
      st_store_dst_h: addr_n = dst_addr + 16'd1;
      default:        addr_n = dst_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_read_q    <= 1'b0;
      mem_write_q   <= 1'b0;
      mem_addr_o    <= '0;
      mem_step_done <= 1'b0;
    end else begin
      mem_step_done <= 1'b0;
      if (read_hit) begin
        mem_read_q    <= 1'b0;
        mem_step_done <= 1'b1;
      end else if (write_hit) begin
        mem_write_q   <= 1'b0;
        mem_step_done <= 1'b1;
      end else if (raise) begin
        mem_read_q  <= is_load;
        mem_write_q <= is_store;
        mem_addr_o  <= addr_n;
      end
    end
  end

  // alu result is settled once exec is over, take it as the store opens
  always_ff @(posedge clk) begin
    if (raise && is_store) begin
      mem_wdata_o <= (state == st_store_dst_h) ? result_h : result;
    end
    if (read_hit) begin
      if (state == st_load_src1) begin
        src1 <= mem_rdata;
      end else begin
        src0 <= mem_rdata;
      end
    end
  end

endmodule

//--- logic/start_manager.sv
`timescale 1ns/1ps

module start_manager import internal_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  state_t            state,
  input  logic [addr_w-1:0] cmd_ptr,
  input  logic              read_dn,
  input  logic [data_w-1:0] mem_rdata,
  output logic              fetch_q,
  output logic [addr_w-1:0] fetch_addr,
  output cmd_word_u         command,
  output logic              start_step_done
);

  logic raise;
  logic fetch_hit;

  // one request per visit to fetch, the done pulse blocks a second one
  assign raise = (state == st_fetch) && !fetch_q && !start_step_done;

  assign fetch_hit = fetch_q && read_dn;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q         <= 1'b0;
      fetch_addr      <= '0;
      start_step_done <= 1'b0;
    end else begin
      start_step_done <= 1'b0;
      if (fetch_hit) begin
        fetch_q         <= 1'b0;
        start_step_done <= 1'b1;
      end else if (raise) begin
        fetch_q    <= 1'b1;
        fetch_addr <= cmd_ptr;
      end
    end
  end

  // held until the next fetch completes
  always_ff @(posedge clk) begin
    if (fetch_hit) begin
      command <= mem_rdata;
    end
  end

endmodule

//--- logic/state_manager.sv
`timescale 1ns/1ps

module state_manager import internal_bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      disp_online,
  input  logic      halt_q,
  input  cmd_word_u command,
  input  logic      start_step_done,
  input  logic      mem_step_done,
  input  logic      finish_step_done,
  input  logic      flag_zero,
  input  logic      flag_neg,
  input  logic      flag_carry,
  input  logic      flags_valid,
  output state_t    state,
  output logic      halted
);

  state_t next_state;
  logic   zero_r;
  logic   neg_r;
  logic   carry_r;
  logic   cond_pass;
  logic   cmd_passed;
  logic   is_ctrl;

  assign is_ctrl = (command.arith.op == op_jmp) || (command.arith.op == op_hlt);
  assign halted  = (state == st_halted);

  // condition against flags of the last arithmetic command
  always_comb begin
    case (command.arith.cond)
      cond_always:   cond_pass = 1'b1;
      cond_zero:     cond_pass = zero_r;
      cond_nonzero:  cond_pass = !zero_r;
      cond_negative: cond_pass = neg_r;
      cond_carry:    cond_pass = carry_r;
      default:       cond_pass = 1'b0;
    endcase
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (disp_online) next_state = st_fetch;
      end
      st_fetch: begin
        if (start_step_done) begin
          if (!cond_pass) next_state = st_finish;
          else if (is_ctrl) next_state = st_exec;
          else next_state = st_load_src1;
        end
      end
      st_load_src1: begin
        // mov has no second operand
        if (mem_step_done) begin
          next_state = (command.arith.op == op_mov) ? st_exec : st_load_src0;
        end
      end
      st_load_src0: begin
        if (mem_step_done) next_state = st_exec;
      end
      st_exec: begin
        next_state = is_ctrl ? st_finish : st_store_dst;
      end
      st_store_dst: begin
        if (mem_step_done) begin
          next_state = (command.arith.op == op_mul) ? st_store_dst_h : st_finish;
        end
      end
      st_store_dst_h: begin
        if (mem_step_done) next_state = st_finish;
      end
      st_finish: begin
        if (finish_step_done) begin
          if (halt_q || (cmd_passed && command.arith.op == op_hlt)) next_state = st_halted;
          else if (disp_online) next_state = st_fetch;
          else next_state = st_idle;
        end
      end
      st_halted: next_state = st_halted;
      default:   next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      cmd_passed <= 1'b0;
      zero_r     <= 1'b0;
      neg_r      <= 1'b0;
      carry_r    <= 1'b0;
    end else begin
      state <= next_state;
      if (state == st_fetch && start_step_done) begin
        cmd_passed <= cond_pass;
      end
      if (flags_valid) begin
        zero_r  <= flag_zero;
        neg_r   <= flag_neg;
        carry_r <= flag_carry;
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_internal_bus -f internal_bus.f

out=$(./obj_dir/Vtb_internal_bus)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi

//--- testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held over the first 5 rising edges
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- testbench/stim_internal_bus.txt
# M addr data: memory preload, E addr data: expected final word (hex)
# I n: idle cycles with disp_online low, C n: commands in the program (decimal)
I 12
C 12
M 0000 00100001
M 0001 10110100
M 0002 01120000
M 0003 84130302
M 0004 92000007
M 0005 40160001
M 0006 A0000000
M 0007 50150204
M 0008 70170300
M 0009 201A0301
M 000A 111B0001
M 000B A0000000
M 0100 00000005
M 0101 00000003
M 0102 80000001
M 0103 12345678
M 0104 00000004
M 0112 5A5A5A5A
M 0116 A5A5A5A5
M 011A FFFFFFFF
E 0110 00000008
E 0111 FFFFFFFE
E 0112 5A5A5A5A
E 0113 12345678
E 0114 091A2B3C
E 0115 00000010
E 0116 A5A5A5A5
E 0117 12345678
E 011A 00000000
E 011B 00000002

//--- testbench/tb_internal_bus.sv
`timescale 1ns/1ps

module tb_internal_bus import internal_bus_pkg::*;;

  logic              clk;
  logic              rst;
  logic              disp_online;
  logic              halt_q;
  logic              read_dn   = 1'b0;
  logic              write_dn  = 1'b0;
  logic [data_w-1:0] mem_rdata = '0;
  logic              read_q;
  logic              write_q;
  logic [addr_w-1:0] mem_addr;
  logic [data_w-1:0] mem_wdata;
  logic              halted;
  state_t            dut_state;

  // memory model and stimulus file contents
  logic [data_w-1:0] mem [0:65535];
  logic [addr_w-1:0] pre_addr[$];
  logic [data_w-1:0] pre_data[$];
  logic [addr_w-1:0] exp_addr[$];
  logic [data_w-1:0] exp_data[$];
  int                idle_len  = 0;
  int                cmd_count = 0;

  // bus model state
  logic              mem_ready  = 1'b0;
  logic              busy       = 1'b0;
  logic              cool       = 1'b0;
  logic              first_seen = 1'b0;
  logic              seen_halt  = 1'b0;
  logic              req_write;
  logic [addr_w-1:0] req_addr;
  logic [data_w-1:0] req_data;
  logic [1:0]        wait_cnt;
  logic [31:0]       lfsr = 32'h3163_3f4f;

  int err_value    = 0;
  int err_protocol = 0;
  int err_other    = 0;

  clock_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  internal_bus u_dut (
    .clk         (clk),
    .rst         (rst),
    .disp_online (disp_online),
    .halt_q      (halt_q),
    .read_dn     (read_dn),
    .write_dn    (write_dn),
    .mem_rdata   (mem_rdata),
    .read_q      (read_q),
    .write_q     (write_q),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .halted      (halted),
    .state       (dut_state)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic load_stim();
    int          fd;
    int          c;
    int          r;
    logic [7:0]  ch;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("testbench/stim_internal_bus.txt", "r");
    if (fd == 0) begin
      err_other++;
      $display("could not open the stimulus file");
      return;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      ch = c[7:0];
      if (ch == "#") begin
        while (c != -1 && c[7:0] != "\n") begin
          c = $fgetc(fd);
        end
      end else if (ch == "M" || ch == "E") begin
        r = $fscanf(fd, "%h %h", a, d);
        if (ch == "M") begin
          pre_addr.push_back(a[addr_w-1:0]);
          pre_data.push_back(d);
        end else begin
          exp_addr.push_back(a[addr_w-1:0]);
          exp_data.push_back(d);
        end
      end else if (ch == "I") begin
        r = $fscanf(fd, "%d", idle_len);
      end else if (ch == "C") begin
        r = $fscanf(fd, "%d", cmd_count);
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // fill from the address bits and lay the program image on top
  task automatic preload_memory();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {~i[15:0], i[15:0]};
    end
    for (int i = 0; i < pre_addr.size(); i++) begin
      mem[pre_addr[i]] = pre_data[i];
    end
  endtask

  task automatic check_request_held();
    logic ok;
    ok = (req_write ? write_q : read_q) && (mem_addr == req_addr);
    if (req_write) begin
      ok = ok && (mem_wdata == req_data);
    end
    assert (ok) else begin
      err_protocol++;
      $display("at %0t a request, its address or its data changed before done", $time);
    end
  endtask

  // memory answers one request at a time after 1 to 4 cycles
  always @(posedge clk) begin
    read_dn  <= 1'b0;
    write_dn <= 1'b0;
    if (rst) begin
      if (!mem_ready) begin
        preload_memory();
        mem_ready = 1'b1;
      end
      busy = 1'b0;
      cool = 1'b0;
    end else begin
      assert (!(read_q && write_q)) else begin
        err_protocol++;
        $display("at %0t read and write were requested together", $time);
      end
      if (!disp_online) begin
        assert (!read_q && !write_q && dut_state == st_idle) else begin
          err_protocol++;
          $display("at %0t the core was not idle while the dispatcher was offline", $time);
        end
      end
      if (seen_halt) begin
        assert (halted && dut_state == st_halted && !read_q && !write_q) else begin
          err_protocol++;
          $display("at %0t the core left halt or raised a request after halting", $time);
        end
      end
      if (halted) begin
        seen_halt = 1'b1;
      end
      if (busy) begin
        check_request_held();
        if (wait_cnt == 2'd0) begin
          if (req_write) begin
            mem[req_addr] = req_data;
            write_dn <= 1'b1;
          end else begin
            mem_rdata <= mem[req_addr];
            read_dn   <= 1'b1;
          end
          busy = 1'b0;
          cool = 1'b1;
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
      end else if (cool) begin
        // request still high in the cycle its done pulse is seen
        check_request_held();
        cool = 1'b0;
      end else if (read_q || write_q) begin
        if (!first_seen) begin
          assert (read_q && mem_addr == '0) else begin
            err_value++;
            $display("Fail %0t: first access at %h, expected a read at 0000", $time, mem_addr);
          end
          first_seen = 1'b1;
        end
        if (write_q) begin
          assert (dut_state == st_store_dst || dut_state == st_store_dst_h) else begin
            err_value++;
            $display("Fail %0t: write raised in state %0d", $time, dut_state);
          end
        end else begin
          assert (dut_state == st_fetch || dut_state == st_load_src1
                  || dut_state == st_load_src0) else begin
            err_value++;
            $display("Fail %0t: read raised in state %0d", $time, dut_state);
          end
        end
        req_write = write_q;
        req_addr  = mem_addr;
        req_data  = mem_wdata;
        lfsr = lfsr_step(lfsr);
        wait_cnt[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        wait_cnt[1] = lfsr[0];
        busy = 1'b1;
      end
    end
  end

  task automatic check_final_memory();
    if (exp_addr.size() == 0) begin
      err_other++;
      $display("the stimulus file holds no expected words");
    end
    for (int i = 0; i < exp_addr.size(); i++) begin
      assert (mem[exp_addr[i]] == exp_data[i]) else begin
        err_value++;
        $display("Fail %0t: mem[%h] = %h, expected %h", $time, exp_addr[i],
                 mem[exp_addr[i]], exp_data[i]);
      end
    end
  endtask

  initial begin : run_control
    int cycles;
    int limit;
    disp_online = 1'b0;
    halt_q      = 1'b0;
    load_stim();
    limit  = 30 * cmd_count + idle_len + 100;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (rst !== 1'b0);
    repeat (idle_len) begin
      @(posedge clk);
      cycles++;
    end
    disp_online <= 1'b1;
    while (!halted && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      err_other++;
      $display("the core never halted within %0d cycles", limit);
    end else begin
      // watch the bus for a while after halt
      repeat (10) @(posedge clk);
      check_final_memory();
    end
    $display("errors: %0d value, %0d protocol, %0d other", err_value, err_protocol,
             err_other);
    if (err_value + err_protocol + err_other == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
